// File: src/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// core side address and data widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// the GP1 window drops the top two address bits
`define BRIDGE_HOST_ADDR_W 30

// core addresses below this value belong to the host window
`define BRIDGE_SPLIT_ADDR 32'h0020_0000

// start of the DRAM space as the core sees it
`define BRIDGE_DRAM_BASE 32'h8000_0000

// exclusive upper bound on the DRAM offset, 120 MiB
`define BRIDGE_DRAM_LIMIT 32'h0780_0000

`define BRIDGE_MBOX_DEPTH 4

// one bit per 8 MiB region of DRAM
`define BRIDGE_PROF_W 128

`endif

// File: src/bridge_bus_pkg.sv
`include "bridge_macros.svh"

package bridge_bus_pkg;

   // one bit is enough since every path carries only reads and writes
   typedef enum logic
   {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

   // request as it arrives through the GP1 window, before translation
   typedef struct packed
   {
      mem_op_e                        op;
      logic [`BRIDGE_HOST_ADDR_W-1:0] addr;
      logic [`BRIDGE_DATA_W-1:0]      data;
   } host_req_s;

   // request at core address scale, used on every path behind the window
   typedef struct packed
   {
      mem_op_e                   op;
      logic [`BRIDGE_ADDR_W-1:0] addr;
      logic [`BRIDGE_DATA_W-1:0] data;
   } mem_req_s;

endpackage

// File: src/bridge_csr_pkg.sv
`include "bridge_macros.svh"

package bridge_csr_pkg;

   // register index of the host shell
   typedef enum logic [3:0]
   {
      CSR_CTRL       = 4'd0,
      CSR_DRAM_VALID = 4'd1,
      CSR_DRAM_BASE  = 4'd2,
      CSR_STATUS     = 4'd3,
      CSR_MAILBOX    = 4'd4,
      CSR_PROF0      = 4'd5,
      CSR_PROF1      = 4'd6,
      CSR_PROF2      = 4'd7,
      CSR_PROF3      = 4'd8
   } csr_addr_e;

   typedef struct packed
   {
      bridge_bus_pkg::mem_op_e   op;
      csr_addr_e                 addr;
      logic [`BRIDGE_DATA_W-1:0] data;
   } csr_req_s;

endpackage

// File: src/bridge_csr_shell.sv
`include "bridge_macros.svh"

module bridge_csr_shell
(
   input  logic                          aclk_i,
   input  logic                          rst_i,
   input  bridge_csr_pkg::csr_req_s      csr_req_i,
   input  logic                          csr_req_v_i,
   input  logic                          range_err_i,
   input  logic                          mbox_overflow_i,
   input  logic [2:0]                    mbox_count_i,
   input  logic [`BRIDGE_DATA_W-1:0]     mbox_head_i,
   input  logic [`BRIDGE_PROF_W-1:0]     prof_i,
   output logic [`BRIDGE_DATA_W-1:0]     csr_rdata_o,
   output logic                          csr_rdata_v_o,
   output logic                          mbox_pop_o,
   output logic [`BRIDGE_DATA_W-1:0]     dram_base_o,
   output logic                          core_reset_o
);
   import bridge_bus_pkg::*;
   import bridge_csr_pkg::*;

   logic                      ctrl_run_r;
   logic [`BRIDGE_DATA_W-1:0] dram_valid_r;
   logic [`BRIDGE_DATA_W-1:0] dram_base_r;
   logic [`BRIDGE_DATA_W-1:0] rd_mux;
   logic [`BRIDGE_DATA_W-1:0] rdata_r;
   logic                      rdata_v_r;
   logic                      is_read;
   logic                      is_write;

   assign is_read  = csr_req_v_i && (csr_req_i.op == MEM_READ);
   assign is_write = csr_req_v_i && (csr_req_i.op == MEM_WRITE);

   // the head is captured at the same edge that advances the mailbox
   assign mbox_pop_o = is_read && (csr_req_i.addr == CSR_MAILBOX);

   // the core stays in reset until the host sets the run bit
   assign core_reset_o = rst_i || !ctrl_run_r;
   assign dram_base_o  = dram_base_r;

   // writes to read-only indices fall through to the default and do nothing
   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         ctrl_run_r   <= 1'b0;
         dram_valid_r <= '0;
         dram_base_r  <= '0;
      end
      else if (is_write)
      begin
         case (csr_req_i.addr)
            CSR_CTRL:       ctrl_run_r   <= csr_req_i.data[0];
            CSR_DRAM_VALID: dram_valid_r <= csr_req_i.data;
            CSR_DRAM_BASE:  dram_base_r  <= csr_req_i.data;
            default:        ;
         endcase
      end
   end

   always_comb
   begin
      case (csr_req_i.addr)
         CSR_CTRL:       rd_mux = {{(`BRIDGE_DATA_W-1){1'b0}}, ctrl_run_r};
         CSR_DRAM_VALID: rd_mux = dram_valid_r;
         CSR_DRAM_BASE:  rd_mux = dram_base_r;
         CSR_STATUS:     rd_mux = {25'b0, mbox_count_i, 2'b00, mbox_overflow_i, range_err_i};
         CSR_MAILBOX:    rd_mux = mbox_head_i;
         CSR_PROF0:      rd_mux = prof_i[0*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_PROF1:      rd_mux = prof_i[1*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_PROF2:      rd_mux = prof_i[2*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         CSR_PROF3:      rd_mux = prof_i[3*`BRIDGE_DATA_W +: `BRIDGE_DATA_W];
         default:        rd_mux = '0;
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (is_read)
      begin
         rdata_r <= rd_mux;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         rdata_v_r <= 1'b0;
      end
      else
      begin
         rdata_v_r <= is_read;
      end
   end

   assign csr_rdata_o   = rdata_r;
   assign csr_rdata_v_o = rdata_v_r;

   // every read gets a response with defined data one cycle after the request
   a_read_response: assert property (@(posedge aclk_i) disable iff (rst_i)
      is_read |=> (csr_rdata_v_o && !$isunknown(csr_rdata_o)));

endmodule

// File: src/mem_access_router.sv
`include "bridge_macros.svh"

module mem_access_router
(
   input  logic                        aclk_i,
   input  logic                        rst_i,
   input  bridge_bus_pkg::host_req_s   host_req_i,
   input  logic                        host_req_v_i,
   input  bridge_bus_pkg::mem_req_s    core_req_i,
   input  logic                        core_req_v_i,
   output bridge_bus_pkg::mem_req_s    core_host_req_o,
   output logic                        core_host_req_v_o,
   output logic                        mbox_push_o,
   output logic [`BRIDGE_DATA_W-1:0]   mbox_data_o,
   output bridge_bus_pkg::mem_req_s    dram_pre_o,
   output logic                        dram_pre_v_o,
   output bridge_bus_pkg::mem_req_s    periph_req_o,
   output logic                        periph_req_v_o
);
   import bridge_bus_pkg::*;

   mem_req_s host_xlat_r;
   mem_req_s core_req_r;
   logic     host_v_r;
   logic     mbox_v_r;
   logic     dram_v_r;
   logic     periph_v_r;
   logic     below_split;
   logic     is_dram;

   assign below_split = core_req_i.addr < `BRIDGE_SPLIT_ADDR;
   assign is_dram     = core_req_i.addr[`BRIDGE_ADDR_W-1];

   // window offset 0x0xxx_xxxx lands in core DRAM at 0x8xxx_xxxx,
   // and offset 0x2xxx_xxxx lands in core local space at 0x0xxx_xxxx
   always_ff @(posedge aclk_i)
   begin
      if (host_req_v_i)
      begin
         host_xlat_r.op   <= host_req_i.op;
         host_xlat_r.addr <= {~host_req_i.addr[29], 3'b000, host_req_i.addr[27:0]};
         host_xlat_r.data <= host_req_i.data;
      end
   end

   // only one stream is valid per cycle so they share one payload register
   always_ff @(posedge aclk_i)
   begin
      if (core_req_v_i)
      begin
         core_req_r <= core_req_i;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         host_v_r   <= 1'b0;
         mbox_v_r   <= 1'b0;
         dram_v_r   <= 1'b0;
         periph_v_r <= 1'b0;
      end
      else
      begin
         host_v_r   <= host_req_v_i;
         mbox_v_r   <= core_req_v_i && below_split;
         dram_v_r   <= core_req_v_i && !below_split && is_dram;
         periph_v_r <= core_req_v_i && !below_split && !is_dram;
      end
   end

   assign core_host_req_o   = host_xlat_r;
   assign core_host_req_v_o = host_v_r;
   assign mbox_push_o       = mbox_v_r;
   assign mbox_data_o       = core_req_r.data;
   assign dram_pre_o        = core_req_r;
   assign dram_pre_v_o      = dram_v_r;
   assign periph_req_o      = core_req_r;
   assign periph_req_v_o    = periph_v_r;

   // the host window only accepts writes from the core, there is no read return
   a_no_host_read: assert property (@(posedge aclk_i) disable iff (rst_i)
      (core_req_v_i && below_split) |-> (core_req_i.op == MEM_WRITE));

endmodule

// File: src/dram_remap.sv
`include "bridge_macros.svh"

module dram_remap
(
   input  logic                        aclk_i,
   input  logic                        rst_i,
   input  bridge_bus_pkg::mem_req_s    dram_pre_i,
   input  logic                        dram_pre_v_i,
   input  logic [`BRIDGE_ADDR_W-1:0]   dram_base_i,
   output bridge_bus_pkg::mem_req_s    dram_req_o,
   output logic                        dram_req_v_o,
   output logic                        range_err_o
);
   import bridge_bus_pkg::*;

   logic [`BRIDGE_ADDR_W-1:0] offset;
   logic                      in_range;
   mem_req_s                  dram_req_r;
   logic                      dram_req_v_r;
   logic                      range_err_r;

   // the core DRAM base has only its top bit set, so xor strips it
   assign offset   = dram_pre_i.addr ^ `BRIDGE_DRAM_BASE;
   assign in_range = offset < `BRIDGE_DRAM_LIMIT;

   always_ff @(posedge aclk_i)
   begin
      if (dram_pre_v_i)
      begin
         dram_req_r.op   <= dram_pre_i.op;
         dram_req_r.addr <= offset + dram_base_i;
         dram_req_r.data <= dram_pre_i.data;
      end
   end

   // out of range requests are dropped here and leave only the error flag
   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         dram_req_v_r <= 1'b0;
         range_err_r  <= 1'b0;
      end
      else
      begin
         dram_req_v_r <= dram_pre_v_i && in_range;
         range_err_r  <= range_err_r || (dram_pre_v_i && !in_range);
      end
   end

   assign dram_req_o   = dram_req_r;
   assign dram_req_v_o = dram_req_v_r;
   assign range_err_o  = range_err_r;

   // an issued address must stay inside the window the host allocated
   a_issue_in_range: assert property (@(posedge aclk_i) disable iff (rst_i)
      dram_req_v_o |-> ((dram_req_o.addr - $past(dram_base_i)) < `BRIDGE_DRAM_LIMIT));

endmodule

// File: src/mem_profiler.sv
`include "bridge_macros.svh"

module mem_profiler
(
   input  logic                        aclk_i,
   input  logic                        core_reset_i,
   input  bridge_bus_pkg::mem_req_s    dram_pre_i,
   input  logic                        dram_pre_v_i,
   output logic [`BRIDGE_PROF_W-1:0]   prof_o
);

   logic [`BRIDGE_PROF_W-1:0] prof_r;
   logic [6:0]                region;

   // address bits 29 to 23 select one of 128 regions of 8 MiB each
   assign region = dram_pre_i.addr[29:23];

   // the map is cleared whenever the core is held in reset,
   // so every program run starts with an empty footprint
   always_ff @(posedge aclk_i)
   begin
      if (core_reset_i)
      begin
         prof_r <= '0;
      end
      else if (dram_pre_v_i)
      begin
         // out of range requests are recorded too, that is the point of the map
         prof_r[region] <= 1'b1;
      end
   end

   assign prof_o = prof_r;

endmodule

// File: src/host_mailbox.sv
`include "bridge_macros.svh"

module host_mailbox
(
   input  logic                        aclk_i,
   input  logic                        rst_i,
   input  logic                        push_i,
   input  logic [`BRIDGE_DATA_W-1:0]   push_data_i,
   input  logic                        pop_i,
   output logic [`BRIDGE_DATA_W-1:0]   head_o,
   output logic [2:0]                  count_o,
   output logic                        overflow_o
);

   localparam int PTR_W = $clog2(`BRIDGE_MBOX_DEPTH);

   logic [`BRIDGE_DATA_W-1:0] mem_r [`BRIDGE_MBOX_DEPTH];
   logic [PTR_W-1:0]          wr_ptr_r;
   logic [PTR_W-1:0]          rd_ptr_r;
   logic [PTR_W:0]            count_r;
   logic                      overflow_r;
   logic                      empty;
   logic                      full;
   logic                      do_push;
   logic                      do_pop;

   assign empty   = count_r == '0;
   assign full    = count_r == `BRIDGE_MBOX_DEPTH;
   assign do_pop  = pop_i && !empty;
   // a pop in the same cycle frees the slot a full FIFO would otherwise refuse
   assign do_push = push_i && (!full || do_pop);

   always_ff @(posedge aclk_i)
   begin
      if (do_push)
      begin
         mem_r[wr_ptr_r] <= push_data_i;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r   <= '0;
         rd_ptr_r   <= '0;
         count_r    <= '0;
         overflow_r <= 1'b0;
      end
      else
      begin
         wr_ptr_r   <= wr_ptr_r + PTR_W'(do_push);
         rd_ptr_r   <= rd_ptr_r + PTR_W'(do_pop);
         count_r    <= count_r + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
         overflow_r <= overflow_r || (push_i && !do_push);
      end
   end

   // an empty mailbox reads as zero
   assign head_o     = empty ? '0 : mem_r[rd_ptr_r];
   assign count_o    = count_r;
   assign overflow_o = overflow_r;

   a_count_bound: assert property (@(posedge aclk_i) disable iff (rst_i)
      count_r <= `BRIDGE_MBOX_DEPTH);

endmodule

// File: src/zynq_bridge_top.sv
`include "bridge_macros.svh"

module zynq_bridge_top
(
   input  logic                        aclk_i,
   input  logic                        rst_i,
   input  bridge_csr_pkg::csr_req_s    csr_req_i,
   input  logic                        csr_req_v_i,
   output logic [`BRIDGE_DATA_W-1:0]   csr_rdata_o,
   output logic                        csr_rdata_v_o,
   input  bridge_bus_pkg::host_req_s   host_req_i,
   input  logic                        host_req_v_i,
   output bridge_bus_pkg::mem_req_s    core_host_req_o,
   output logic                        core_host_req_v_o,
   input  bridge_bus_pkg::mem_req_s    core_req_i,
   input  logic                        core_req_v_i,
   output logic                        core_reset_o,
   output bridge_bus_pkg::mem_req_s    dram_req_o,
   output logic                        dram_req_v_o,
   output bridge_bus_pkg::mem_req_s    periph_req_o,
   output logic                        periph_req_v_o
);
   import bridge_bus_pkg::*;

   mem_req_s                  dram_pre;
   logic                      dram_pre_v;
   logic                      mbox_push;
   logic [`BRIDGE_DATA_W-1:0] mbox_data;
   logic                      mbox_pop;
   logic [`BRIDGE_DATA_W-1:0] mbox_head;
   logic [2:0]                mbox_count;
   logic                      mbox_overflow;
   logic                      range_err;
   logic [`BRIDGE_ADDR_W-1:0] dram_base;
   logic [`BRIDGE_PROF_W-1:0] prof;

   bridge_csr_shell u_shell
   (
      .aclk_i          (aclk_i),
      .rst_i           (rst_i),
      .csr_req_i       (csr_req_i),
      .csr_req_v_i     (csr_req_v_i),
      .range_err_i     (range_err),
      .mbox_overflow_i (mbox_overflow),
      .mbox_count_i    (mbox_count),
      .mbox_head_i     (mbox_head),
      .prof_i          (prof),
      .csr_rdata_o     (csr_rdata_o),
      .csr_rdata_v_o   (csr_rdata_v_o),
      .mbox_pop_o      (mbox_pop),
      .dram_base_o     (dram_base),
      .core_reset_o    (core_reset_o)
   );

   mem_access_router u_router
   (
      .aclk_i            (aclk_i),
      .rst_i             (rst_i),
      .host_req_i        (host_req_i),
      .host_req_v_i      (host_req_v_i),
      .core_req_i        (core_req_i),
      .core_req_v_i      (core_req_v_i),
      .core_host_req_o   (core_host_req_o),
      .core_host_req_v_o (core_host_req_v_o),
      .mbox_push_o       (mbox_push),
      .mbox_data_o       (mbox_data),
      .dram_pre_o        (dram_pre),
      .dram_pre_v_o      (dram_pre_v),
      .periph_req_o      (periph_req_o),
      .periph_req_v_o    (periph_req_v_o)
   );

   dram_remap u_remap
   (
      .aclk_i       (aclk_i),
      .rst_i        (rst_i),
      .dram_pre_i   (dram_pre),
      .dram_pre_v_i (dram_pre_v),
      .dram_base_i  (dram_base),
      .dram_req_o   (dram_req_o),
      .dram_req_v_o (dram_req_v_o),
      .range_err_o  (range_err)
   );

   // the profiler follows the core reset, not the shell reset
   mem_profiler u_profiler
   (
      .aclk_i       (aclk_i),
      .core_reset_i (core_reset_o),
      .dram_pre_i   (dram_pre),
      .dram_pre_v_i (dram_pre_v),
      .prof_o       (prof)
   );

   host_mailbox u_mailbox
   (
      .aclk_i      (aclk_i),
      .rst_i       (rst_i),
      .push_i      (mbox_push),
      .push_data_i (mbox_data),
      .pop_i       (mbox_pop),
      .head_o      (mbox_head),
      .count_o     (mbox_count),
      .overflow_o  (mbox_overflow)
   );

endmodule

// File: test/zynq_bridge_tests.svh
   // each request helper raises its strobe for exactly one cycle and returns
   // just after the edge where the DUT captured it

   task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
      csr_req_s req;
      req.op   = MEM_WRITE;
      req.addr = addr;
      req.data = data;
      @(posedge aclk);
      csr_req   <= req;
      csr_req_v <= 1'b1;
      @(posedge aclk);
      csr_req_v <= 1'b0;
   endtask

   task automatic read_csr(input csr_addr_e addr, output logic [31:0] data);
      csr_req_s req;
      req.op   = MEM_READ;
      req.addr = addr;
      req.data = '0;
      @(posedge aclk);
      csr_req   <= req;
      csr_req_v <= 1'b1;
      @(posedge aclk);
      csr_req_v <= 1'b0;
      @(negedge aclk);
      if (!csr_rdata_v)
      begin
         log_error($sformatf("no read response one cycle after reading %s", addr.name()));
      end
      data = csr_rdata;
   endtask

   task automatic expect_csr(input csr_addr_e addr, input logic [31:0] exp);
      logic [31:0] data;
      read_csr(addr, data);
      check_word($sformatf("csr_rdata_o %s", addr.name()), data, exp);
   endtask

   task automatic send_host_req(input mem_op_e op, input logic [29:0] addr,
                                input logic [31:0] data);
      host_req_s req;
      req.op   = op;
      req.addr = addr;
      req.data = data;
      @(posedge aclk);
      host_req   <= req;
      host_req_v <= 1'b1;
      @(posedge aclk);
      host_req_v <= 1'b0;
   endtask

   task automatic send_core_req(input mem_op_e op, input logic [31:0] addr,
                                input logic [31:0] data);
      mem_req_s req;
      req.op   = op;
      req.addr = addr;
      req.data = data;
      @(posedge aclk);
      core_req   <= req;
      core_req_v <= 1'b1;
      @(posedge aclk);
      core_req_v <= 1'b0;
   endtask

   // translated request must show up for exactly the one cycle after the request
   task automatic expect_host_out(input mem_req_s exp);
      @(negedge aclk);
      if (!core_host_req_v)
      begin
         log_error("no translated host request one cycle after the host request");
      end
      check_req("core_host_req_o", core_host_req, exp);
      @(negedge aclk);
      if (core_host_req_v)
      begin
         log_error("core_host_req_v_o stayed high for more than one cycle");
      end
   endtask

   task automatic test_reset_control();
      int          errors_before;
      logic [31:0] valid_word;
      logic [31:0] base_word;
      errors_before = error_count;
      @(negedge aclk);
      check_word("core_reset_o", {31'b0, core_reset}, 32'h1);
      for (int i = 0; i <= CSR_PROF3; i++)
      begin
         expect_csr(csr_addr_e'(i), 32'h0);
      end
      write_csr(CSR_CTRL, 32'h1);
      @(negedge aclk);
      check_word("core_reset_o", {31'b0, core_reset}, 32'h0);
      valid_word = next_word();
      base_word  = next_word();
      write_csr(CSR_DRAM_VALID, valid_word);
      write_csr(CSR_DRAM_BASE, base_word);
      expect_csr(CSR_DRAM_VALID, valid_word);
      expect_csr(CSR_DRAM_BASE, base_word);
      expect_csr(CSR_CTRL, 32'h1);
      // STATUS is read-only, so this write must leave it untouched
      write_csr(CSR_STATUS, 32'hffff_ffff);
      expect_csr(CSR_STATUS, 32'h0);
      report_test("reset_control", errors_before);
   endtask

   task automatic test_host_window();
      int       errors_before;
      mem_req_s exp;
      errors_before = error_count;
      exp.op   = MEM_WRITE;
      exp.addr = 32'h8000_1234;
      exp.data = next_word();
      send_host_req(MEM_WRITE, 30'h0000_1234, exp.data);
      expect_host_out(exp);
      exp.op   = MEM_READ;
      exp.addr = 32'h0000_0040;
      exp.data = next_word();
      send_host_req(MEM_READ, 30'h2000_0040, exp.data);
      expect_host_out(exp);
      report_test("host_window", errors_before);
   endtask

   task automatic test_dram_remap();
      int       errors_before;
      mem_req_s exp;
      errors_before = error_count;
      write_csr(CSR_DRAM_BASE, 32'h1000_0000);
      exp.op   = MEM_WRITE;
      exp.addr = 32'h1000_0100;
      exp.data = next_word();
      send_core_req(MEM_WRITE, 32'h8000_0100, exp.data);
      @(negedge aclk);
      if (dram_req_v)
      begin
         log_error("DRAM request issued one cycle after the core request instead of two");
      end
      @(negedge aclk);
      if (!dram_req_v)
      begin
         log_error("no DRAM request two cycles after the core request");
      end
      check_req("dram_req_o", dram_req, exp);
      expect_csr(CSR_STATUS, status_word(1'b0, 1'b0, 0));
      // offset of exactly 120 MiB is the first one out of range
      send_core_req(MEM_WRITE, 32'h8780_0000, next_word());
      repeat (3)
      begin
         @(negedge aclk);
         if (dram_req_v)
         begin
            log_error("out of range request reached the DRAM port");
         end
      end
      expect_csr(CSR_STATUS, status_word(1'b1, 1'b0, 0));
      report_test("dram_remap", errors_before);
   endtask

   task automatic test_routing_mailbox();
      int          errors_before;
      mem_req_s    exp;
      logic [31:0] words [5];
      errors_before = error_count;
      exp.op   = MEM_WRITE;
      exp.addr = 32'h4000_0000;
      exp.data = next_word();
      send_core_req(exp.op, exp.addr, exp.data);
      @(negedge aclk);
      if (!periph_req_v)
      begin
         log_error("no peripheral request one cycle after the core request");
      end
      check_req("periph_req_o", periph_req, exp);
      for (int i = 0; i < 3; i++)
      begin
         words[i] = next_word();
         send_core_req(MEM_WRITE, 32'h0000_0100 + 32'(4 * i), words[i]);
      end
      expect_csr(CSR_STATUS, status_word(1'b1, 1'b0, 3));
      for (int i = 0; i < 3; i++)
      begin
         expect_csr(CSR_MAILBOX, words[i]);
      end
      expect_csr(CSR_STATUS, status_word(1'b1, 1'b0, 0));
      for (int i = 0; i < 5; i++)
      begin
         words[i] = next_word();
         send_core_req(MEM_WRITE, 32'h0000_0200 + 32'(4 * i), words[i]);
      end
      expect_csr(CSR_STATUS, status_word(1'b1, 1'b1, 4));
      for (int i = 0; i < 4; i++)
      begin
         expect_csr(CSR_MAILBOX, words[i]);
      end
      // the fifth word was dropped, so the mailbox is empty and reads zero
      expect_csr(CSR_MAILBOX, 32'h0);
      expect_csr(CSR_STATUS, status_word(1'b1, 1'b1, 0));
      report_test("routing_mailbox", errors_before);
   endtask

   task automatic test_profiler();
      int errors_before;
      errors_before = error_count;
      // restart the core so earlier DRAM traffic leaves no trace in the map
      write_csr(CSR_CTRL, 32'h0);
      write_csr(CSR_CTRL, 32'h1);
      send_core_req(MEM_READ, 32'h8000_0000, 32'h0);
      send_core_req(MEM_READ, 32'h8100_0000, 32'h0);
      repeat (2) @(posedge aclk);
      // 16 MiB lands in the third 8 MiB region
      expect_csr(CSR_PROF0, 32'h0000_0005);
      expect_csr(CSR_PROF1, 32'h0);
      expect_csr(CSR_PROF2, 32'h0);
      expect_csr(CSR_PROF3, 32'h0);
      write_csr(CSR_CTRL, 32'h0);
      write_csr(CSR_CTRL, 32'h1);
      expect_csr(CSR_PROF0, 32'h0);
      expect_csr(CSR_PROF1, 32'h0);
      expect_csr(CSR_PROF2, 32'h0);
      expect_csr(CSR_PROF3, 32'h0);
      report_test("profiler", errors_before);
   endtask

// File: test/zynq_bridge_tb.sv
`include "bridge_macros.svh"

module zynq_bridge_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import bridge_bus_pkg::*;
   import bridge_csr_pkg::*;

   localparam int CLK_HALF = 2;
   // the directed tests take well under 200 cycles and this leaves a wide margin
   localparam int WATCHDOG_CYCLES = 2000;

   logic                      aclk = 1'b0;
   logic                      rst;
   csr_req_s                  csr_req;
   logic                      csr_req_v;
   logic [`BRIDGE_DATA_W-1:0] csr_rdata;
   logic                      csr_rdata_v;
   host_req_s                 host_req;
   logic                      host_req_v;
   mem_req_s                  core_host_req;
   logic                      core_host_req_v;
   mem_req_s                  core_req;
   logic                      core_req_v;
   logic                      core_reset;
   mem_req_s                  dram_req;
   logic                      dram_req_v;
   mem_req_s                  periph_req;
   logic                      periph_req_v;

   int          error_count  = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   logic [31:0] rng_state    = 32'd23;

   always #CLK_HALF aclk = ~aclk;

   zynq_bridge_top uut
   (
      .aclk_i            (aclk),
      .rst_i             (rst),
      .csr_req_i         (csr_req),
      .csr_req_v_i       (csr_req_v),
      .csr_rdata_o       (csr_rdata),
      .csr_rdata_v_o     (csr_rdata_v),
      .host_req_i        (host_req),
      .host_req_v_i      (host_req_v),
      .core_host_req_o   (core_host_req),
      .core_host_req_v_o (core_host_req_v),
      .core_req_i        (core_req),
      .core_req_v_i      (core_req_v),
      .core_reset_o      (core_reset),
      .dram_req_o        (dram_req),
      .dram_req_v_o      (dram_req_v),
      .periph_req_o      (periph_req),
      .periph_req_v_o    (periph_req_v)
   );

   // 32-bit xorshift, one new data word per call
   function automatic logic [31:0] next_word();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // STATUS holds range error in bit 0, overflow in bit 1 and the count in bits 6 to 4
   function automatic logic [31:0] status_word(input logic range_err, input logic overflow,
                                               input int count);
      return (32'(count) << 4) | (32'(overflow) << 1) | 32'(range_err);
   endfunction

   task automatic log_error(input string what);
      error_count++;
      $display("error at %0d ns: %s", $time, what);
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
      begin
         error_count++;
         $display("[FAIL] time %0d ns %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_req(input string name, input mem_req_s got, input mem_req_s exp);
      string got_s;
      string exp_s;
      if (got !== exp)
      begin
         error_count++;
         got_s = $sformatf("op %0d addr %h data %h", got.op, got.addr, got.data);
         exp_s = $sformatf("op %0d addr %h data %h", exp.op, exp.addr, exp.data);
         $display("[FAIL] time %0d ns %s: got %s, expected %s", $time, name, got_s, exp_s);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (error_count == errors_before)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, error_count - errors_before);
      end
   endtask

`include "zynq_bridge_tests.svh"

   initial
   begin
      rst        = 1'b1;
      csr_req    = '0;
      csr_req_v  = 1'b0;
      host_req   = '0;
      host_req_v = 1'b0;
      core_req   = '0;
      core_req_v = 1'b0;
      repeat (2) @(posedge aclk);
      rst <= 1'b0;
      @(posedge aclk);
      test_reset_control();
      test_host_window();
      test_dram_remap();
      test_routing_mailbox();
      test_profiler();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
      if (error_count == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge aclk);
      $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: zynq_bridge_top.f
+incdir+src
+incdir+test
src/bridge_bus_pkg.sv
src/bridge_csr_pkg.sv
src/bridge_csr_shell.sv
src/mem_access_router.sv
src/dram_remap.sv
src/mem_profiler.sv
src/host_mailbox.sv
src/zynq_bridge_top.sv
test/zynq_bridge_tb.sv
